//--- project.f
common/controlPkg.sv
source/instrDecode.sv
sequencer/controlSequencer.sv
sequencer/controlWordTable.sv
source/controlUnit.sv
verif/tbClockGen.sv
verif/controlUnit_sva.sv
verif/controlUnitTb.sv

//--- run.sh
#!/bin/sh
# Build and run the control unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert --top-module controlUnitTb -f project.f -o simv; then
	echo "verilator build failed"
	exit 1
fi

# Keep running after an assertion error so the testbench prints its verdict
if ! output=$(./obj_dir/simv +verilator+error+limit+1000); then
	echo "$output"
	echo "simulation exited with an error"
	exit 1
fi

echo "$output"

if echo "$output" | grep -qx "RESULT: PASS"; then
	exit 0
fi
exit 1

//--- verif/controlUnitTb.sv
`default_nettype none

module controlUnitTb;

	localparam int ClkPeriod = 40;
	localparam int DriveDelay = 5;
	localparam int RandomCount = 200;
	// 17 directed instructions plus the random stream
	// Longest instruction is 12 cycles
	localparam int NumInstr = 17 + RandomCount;
	localparam int MaxInstrCycles = 12;
	localparam int TimeLimit = (NumInstr * MaxInstrCycles + 40) * ClkPeriod;

	logic clk;
	logic arstN;
	controlPkg::opcodeT opcode;
	controlPkg::functT funct;
	controlPkg::ctrlWordT ctrl;

	// Position of the current cycle, as seen by the reference
	controlPkg::opcodeT expOpcode;
	controlPkg::functT expFunct;
	int expOffset;
	bit checkEnable;
	string testName;
	int errorCount;
	int checkedCount;
	int testCount;
	int passCount;
	int testErrStart;
	integer seed;

	tbClockGen clkGen_i (
		.clk(clk),
		.arstN(arstN)
	);

	controlUnit dut_i (
		.clk(clk),
		.arstN(arstN),
		.opcode(opcode),
		.funct(funct),
		.ctrl(ctrl)
	);

	function automatic controlPkg::instrClassT classOf(input controlPkg::opcodeT op,
		input controlPkg::functT fn);
		classOf = controlPkg::clsNone;
		if (op == controlPkg::OpAddi)
			classOf = controlPkg::clsAddi;
		else if (op == controlPkg::OpBeq)
			classOf = controlPkg::clsBeq;
		else if (op == controlPkg::OpRType)
		begin
			case (fn)
				controlPkg::FnAdd, controlPkg::FnSub, controlPkg::FnAnd:
					classOf = controlPkg::clsAluR;
				controlPkg::FnSlt:
					classOf = controlPkg::clsSlt;
				controlPkg::FnSrl, controlPkg::FnSra, controlPkg::FnSll,
				controlPkg::FnSllv, controlPkg::FnSrav:
					classOf = controlPkg::clsShift;
				controlPkg::FnJr:
					classOf = controlPkg::clsJr;
				controlPkg::FnBreak:
					classOf = controlPkg::clsBreak;
				controlPkg::FnRte:
					classOf = controlPkg::clsRte;
				default:
					classOf = controlPkg::clsNone;
			endcase
		end
	endfunction

	function automatic int execLength(input controlPkg::opcodeT op, input controlPkg::functT fn);
		case (classOf(op, fn))
			controlPkg::clsAluR, controlPkg::clsSlt, controlPkg::clsJr:
				execLength = 4;
			controlPkg::clsAddi:
				execLength = 3;
			controlPkg::clsShift, controlPkg::clsBreak:
				execLength = 5;
			controlPkg::clsRte:
				execLength = 1;
			controlPkg::clsBeq:
				execLength = 7;
			default:
				execLength = 0;
		endcase
	endfunction

	// Offset 0 is phPcIncr and 5 is the first execute step
	// Offset -2 is the SP init cycle
	function automatic controlPkg::ctrlWordT refWord(input controlPkg::opcodeT op,
		input controlPkg::functT fn, input int offset);
		controlPkg::ctrlWordT w;
		int s;
		w = '0;
		s = offset - 5;
		if (offset == -2)
		begin
			w.regWrite = 1'b1;
			w.regDst = controlPkg::dstStackPtr;
			w.writeData = controlPkg::wdSpInit;
		end
		else if (offset == 0)
		begin
			w.pcWrite = 1'b1;
			w.aluSrcA = controlPkg::srcAPc;
			w.aluSrcB = controlPkg::srcBFour;
			w.aluOp = controlPkg::aluAdd;
			w.pcSource = controlPkg::pcAluResult;
		end
		else if (offset == 2)
			w.irWrite = 1'b1;
		else if (s >= 0)
		begin
			case (classOf(op, fn))
				controlPkg::clsAluR:
				begin
					if (s == 0)
					begin
						w.aWrite = 1'b1;
						w.bWrite = 1'b1;
						w.aluSrcA = controlPkg::srcARegA;
						w.aluSrcB = controlPkg::srcBRegB;
						w.aluOutWrite = 1'b1;
						if (fn == controlPkg::FnAdd)
							w.aluOp = controlPkg::aluAdd;
						else if (fn == controlPkg::FnSub)
							w.aluOp = controlPkg::aluSub;
						else
							w.aluOp = controlPkg::aluAnd;
					end
					else if (s == 2)
					begin
						w.regWrite = 1'b1;
						w.regDst = controlPkg::dstRd;
						w.writeData = controlPkg::wdAluOut;
					end
				end
				controlPkg::clsAddi:
				begin
					if (s == 0)
					begin
						w.aWrite = 1'b1;
						w.aluSrcA = controlPkg::srcARegA;
						w.aluSrcB = controlPkg::srcBImm;
						w.aluOp = controlPkg::aluAdd;
						w.aluOutWrite = 1'b1;
					end
					else if (s == 2)
					begin
						w.regWrite = 1'b1;
						w.regDst = controlPkg::dstRt;
						w.writeData = controlPkg::wdAluOut;
					end
				end
				controlPkg::clsSlt:
				begin
					if (s == 0)
					begin
						w.aWrite = 1'b1;
						w.bWrite = 1'b1;
						w.aluSrcA = controlPkg::srcARegA;
						w.aluSrcB = controlPkg::srcBRegB;
						w.aluOp = controlPkg::aluSlt;
					end
					else if (s == 1 || s == 2)
					begin
						w.regWrite = 1'b1;
						w.regDst = controlPkg::dstRd;
						w.writeData = controlPkg::wdLessThan;
					end
				end
				controlPkg::clsShift:
				begin
					if (s == 0)
					begin
						w.aluSrcA = controlPkg::srcARegA;
						if (fn == controlPkg::FnSllv || fn == controlPkg::FnSrav)
							w.shiftLoad = controlPkg::ldVariable;
						else
						begin
							w.aWrite = 1'b1;
							w.bWrite = 1'b1;
							w.shiftLoad = controlPkg::ldImmediate;
							w.shamtFromField = 1'b1;
						end
					end
					else if (s == 1)
					begin
						if (fn == controlPkg::FnSrl)
							w.shiftOp = controlPkg::shRightLogic;
						else if (fn == controlPkg::FnSra || fn == controlPkg::FnSrav)
							w.shiftOp = controlPkg::shRightArith;
						else
							w.shiftOp = controlPkg::shLeft;
					end
					else if (s == 2 || s == 3)
					begin
						w.regWrite = 1'b1;
						w.regDst = controlPkg::dstRd;
						w.writeData = controlPkg::wdShifter;
					end
				end
				controlPkg::clsJr:
				begin
					if (s == 0)
					begin
						w.aluSrcA = controlPkg::srcAJump;
						w.aluSrcB = controlPkg::srcBZero;
						w.aluOp = controlPkg::aluAdd;
						w.aluOutWrite = 1'b1;
					end
					else if (s == 1 || s == 2)
					begin
						w.pcWrite = 1'b1;
						w.pcSource = controlPkg::pcAluOut;
					end
				end
				controlPkg::clsBreak:
				begin
					if (s == 0)
					begin
						w.aWrite = 1'b1;
						w.bWrite = 1'b1;
						w.aluSrcA = controlPkg::srcAPc;
						w.aluSrcB = controlPkg::srcBFour;
						w.aluOp = controlPkg::aluSub;
					end
					else if (s >= 1 && s <= 3)
					begin
						w.pcWrite = 1'b1;
						w.pcSource = controlPkg::pcAluResult;
					end
				end
				controlPkg::clsRte:
				begin
					w.pcWrite = 1'b1;
					w.pcSource = controlPkg::pcEpc;
				end
				controlPkg::clsBeq:
				begin
					if (s == 1)
					begin
						w.aluSrcA = controlPkg::srcAPc;
						w.aluSrcB = controlPkg::srcBOffset;
						w.aluOp = controlPkg::aluAdd;
						w.aluOutWrite = 1'b1;
					end
					else if (s == 3)
					begin
						w.aWrite = 1'b1;
						w.bWrite = 1'b1;
						w.aluSrcA = controlPkg::srcARegA;
						w.aluSrcB = controlPkg::srcBRegB;
						w.aluOp = controlPkg::aluSub;
					end
					else if (s == 4)
					begin
						w.pcWriteCond = 1'b1;
						w.branchEqual = 2'd1;
						w.pcSource = controlPkg::pcAluOut;
					end
				end
				default:
					w = '0;
			endcase
		end
		refWord = w;
	endfunction

	// R-type function codes of the random stream
	function automatic controlPkg::functT keptFunct(input int idx);
		case (idx)
			0: keptFunct = controlPkg::FnAdd;
			1: keptFunct = controlPkg::FnSub;
			2: keptFunct = controlPkg::FnAnd;
			3: keptFunct = controlPkg::FnSlt;
			4: keptFunct = controlPkg::FnSrl;
			5: keptFunct = controlPkg::FnSra;
			6: keptFunct = controlPkg::FnSll;
			7: keptFunct = controlPkg::FnSllv;
			8: keptFunct = controlPkg::FnSrav;
			9: keptFunct = controlPkg::FnJr;
			10: keptFunct = controlPkg::FnBreak;
			default: keptFunct = controlPkg::FnRte;
		endcase
	endfunction

	task automatic nextCycle;
		@(posedge clk);
		#(DriveDelay);
	endtask

	// Holds opcode and funct for the whole instruction including fetch
	task automatic runInstr(input controlPkg::opcodeT op, input controlPkg::functT fn);
		int total;
		int i;
		total = 5 + execLength(op, fn);
		for (i = 0; i < total; i++)
		begin
			opcode = op;
			funct = fn;
			expOpcode = op;
			expFunct = fn;
			expOffset = i;
			nextCycle();
		end
	endtask

	task automatic startTest(input string name);
		testName = name;
		testErrStart = errorCount;
	endtask

	task automatic finishTest;
		testCount++;
		if (errorCount == testErrStart)
		begin
			passCount++;
			$display("test %s: passed", testName);
		end
		else
			$display("test %s: failed with %0d mismatches", testName, errorCount - testErrStart);
	endtask

	initial
	begin : stimulus
		int idx;
		int n;
		controlPkg::opcodeT op;
		controlPkg::functT fn;
		opcode = '0;
		funct = '0;
		expOpcode = '0;
		expFunct = '0;
		expOffset = -3;
		errorCount = 0;
		checkedCount = 0;
		testCount = 0;
		passCount = 0;
		seed = 42;
		checkEnable = 1'b0;

		// Reset followed by phReset, phSpInit and phIdle
		startTest("startup");
		@(posedge clk);
		checkEnable = 1'b1;
		wait (arstN === 1'b1);
		nextCycle();
		expOffset = -2;
		nextCycle();
		expOffset = -1;
		nextCycle();
		finishTest();

		startTest("alu");
		runInstr(controlPkg::OpRType, controlPkg::FnAdd);
		runInstr(controlPkg::OpRType, controlPkg::FnSub);
		runInstr(controlPkg::OpRType, controlPkg::FnAnd);
		runInstr(controlPkg::OpRType, controlPkg::FnSlt);
		runInstr(controlPkg::OpAddi, 6'd0);
		finishTest();

		startTest("shift");
		runInstr(controlPkg::OpRType, controlPkg::FnSrl);
		runInstr(controlPkg::OpRType, controlPkg::FnSra);
		runInstr(controlPkg::OpRType, controlPkg::FnSll);
		runInstr(controlPkg::OpRType, controlPkg::FnSllv);
		runInstr(controlPkg::OpRType, controlPkg::FnSrav);
		finishTest();

		startTest("transfer");
		runInstr(controlPkg::OpRType, controlPkg::FnJr);
		runInstr(controlPkg::OpRType, controlPkg::FnBreak);
		runInstr(controlPkg::OpRType, controlPkg::FnRte);
		runInstr(controlPkg::OpBeq, 6'd0);
		finishTest();

		// Unknown codes fall back to fetch
		// The add after them shows the next fetch
		startTest("unknown");
		runInstr(6'd63, 6'd0);
		runInstr(controlPkg::OpRType, 6'd1);
		runInstr(controlPkg::OpRType, controlPkg::FnAdd);
		finishTest();

		startTest("random");
		for (n = 0; n < RandomCount; n++)
		begin
			idx = $unsigned($random(seed)) % 14;
			fn = controlPkg::functT'($random(seed));
			if (idx == 12)
				op = controlPkg::OpAddi;
			else if (idx == 13)
				op = controlPkg::OpBeq;
			else
			begin
				op = controlPkg::OpRType;
				fn = keptFunct(idx);
			end
			runInstr(op, fn);
		end
		checkEnable = 1'b0;
		finishTest();

		$display("tests %0d, passed %0d, checked %0d, mismatches %0d, assertion failures %0d",
			testCount, passCount, checkedCount, errorCount, dut_i.sva_i.failCount);
		if (errorCount == 0 && passCount == testCount && dut_i.sva_i.failCount == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	// Output is stable by the falling edge
	always @(negedge clk)
	begin : compare
		controlPkg::ctrlWordT expected;
		if (checkEnable)
		begin
			expected = refWord(expOpcode, expFunct, expOffset);
			checkedCount++;
			if (ctrl !== expected)
			begin
				errorCount++;
				$display("mismatch in test %s at offset %0d: expected %h, actual %h",
					testName, expOffset, expected, ctrl);
			end
		end
	end

	initial
	begin : watchdog
		#(TimeLimit);
		$display("timeout: test %s still running after %0d time units", testName, TimeLimit);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- verif/controlUnit_sva.sv
`default_nettype none

module controlUnit_sva (
	input wire clk,
	input wire arstN,
	input wire controlPkg::ctrlWordT ctrl
);

	int failCount = 0;

	// Only one kind of PC write per cycle
	assert property (@(posedge clk) disable iff (!arstN)
		!(ctrl.pcWrite && ctrl.pcWriteCond))
		else
		begin
			failCount++;
			$error("pcWrite and pcWriteCond high together");
		end

	assert property (@(posedge clk) disable iff (!arstN)
		!(ctrl.regWrite && ctrl.pcWrite))
		else
		begin
			failCount++;
			$error("regWrite and pcWrite high together");
		end

	// Instruction register loads for a single cycle
	assert property (@(posedge clk) disable iff (!arstN)
		ctrl.irWrite |=> !ctrl.irWrite)
		else
		begin
			failCount++;
			$error("irWrite high for two cycles in a row");
		end

	assert property (@(posedge clk)
		!arstN |-> (ctrl == '0))
		else
		begin
			failCount++;
			$error("control word not zero during reset");
		end

endmodule

bind controlUnit controlUnit_sva sva_i (
	.clk(clk),
	.arstN(arstN),
	.ctrl(ctrl)
);

`default_nettype wire

//--- verif/tbClockGen.sv
`default_nettype none

module tbClockGen (
	output logic clk,
	output logic arstN
);

	// 40 time unit period
	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Reset held over two rising edges, released just after the second
	initial
	begin
		arstN = 1'b0;
		repeat (2) @(posedge clk);
		#5 arstN = 1'b1;
	end

endmodule

`default_nettype wire

//--- source/controlUnit.sv
`default_nettype none

module controlUnit (
	input wire clk,
	input wire arstN,
	input wire controlPkg::opcodeT opcode,
	input wire controlPkg::functT funct,
	output controlPkg::ctrlWordT ctrl
);

	controlPkg::decodedT decoded;
	controlPkg::decodedT instr;
	controlPkg::phaseT phase;
	controlPkg::stepT step;

	instrDecode decode_i (
		.opcode(opcode),
		.funct(funct),
		.decoded(decoded)
	);

	controlSequencer sequencer_i (
		.clk(clk),
		.arstN(arstN),
		.decoded(decoded),
		.phase(phase),
		.step(step),
		.instr(instr)
	);

	controlWordTable table_i (
		.phase(phase),
		.step(step),
		.instr(instr),
		.ctrl(ctrl)
	);

endmodule

`default_nettype wire

//--- sequencer/controlWordTable.sv
`default_nettype none

module controlWordTable (
	input wire controlPkg::phaseT phase,
	input wire controlPkg::stepT step,
	input wire controlPkg::decodedT instr,
	output controlPkg::ctrlWordT ctrl
);

	always_comb
	begin
		ctrl = '0;
		case (phase)
			controlPkg::phSpInit:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.regDst = controlPkg::dstStackPtr;
				ctrl.writeData = controlPkg::wdSpInit;
			end
			controlPkg::phPcIncr:
			begin
				ctrl.pcWrite = 1'b1;
				ctrl.aluSrcA = controlPkg::srcAPc;
				ctrl.aluSrcB = controlPkg::srcBFour;
				ctrl.aluOp = controlPkg::aluAdd;
				ctrl.pcSource = controlPkg::pcAluResult;
			end
			controlPkg::phIrLoad:
				ctrl.irWrite = 1'b1;
			controlPkg::phExecute:
			begin
				case (instr.cls)
					controlPkg::clsAluR:
					begin
						if (step == 3'd0)
						begin
							ctrl.aWrite = 1'b1;
							ctrl.bWrite = 1'b1;
							ctrl.aluSrcA = controlPkg::srcARegA;
							ctrl.aluSrcB = controlPkg::srcBRegB;
							ctrl.aluOp = instr.aluOp;
							ctrl.aluOutWrite = 1'b1;
						end
						else if (step == 3'd2)
						begin
							ctrl.regWrite = 1'b1;
							ctrl.regDst = controlPkg::dstRd;
							ctrl.writeData = controlPkg::wdAluOut;
						end
					end
					controlPkg::clsAddi:
					begin
						if (step == 3'd0)
						begin
							ctrl.aWrite = 1'b1;
							ctrl.aluSrcA = controlPkg::srcARegA;
							ctrl.aluSrcB = controlPkg::srcBImm;
							ctrl.aluOp = controlPkg::aluAdd;
							ctrl.aluOutWrite = 1'b1;
						end
						else if (step == 3'd2)
						begin
							ctrl.regWrite = 1'b1;
							ctrl.regDst = controlPkg::dstRt;
							ctrl.writeData = controlPkg::wdAluOut;
						end
					end
					controlPkg::clsSlt:
					begin
						if (step == 3'd0)
						begin
							ctrl.aWrite = 1'b1;
							ctrl.bWrite = 1'b1;
							ctrl.aluSrcA = controlPkg::srcARegA;
							ctrl.aluSrcB = controlPkg::srcBRegB;
							ctrl.aluOp = controlPkg::aluSlt;
						end
						else if (step inside {3'd1, 3'd2})
						begin
							ctrl.regWrite = 1'b1;
							ctrl.regDst = controlPkg::dstRd;
							ctrl.writeData = controlPkg::wdLessThan;
						end
					end
					controlPkg::clsShift:
					begin
						if (step == 3'd0)
						begin
							ctrl.aluSrcA = controlPkg::srcARegA;
							if (instr.shiftVariable)
								ctrl.shiftLoad = controlPkg::ldVariable;
							else
							begin
								// Amount comes from the shamt field
								ctrl.aWrite = 1'b1;
								ctrl.bWrite = 1'b1;
								ctrl.shiftLoad = controlPkg::ldImmediate;
								ctrl.shamtFromField = 1'b1;
							end
						end
						else if (step == 3'd1)
							ctrl.shiftOp = instr.shiftOp;
						else if (step inside {3'd2, 3'd3})
						begin
							ctrl.regWrite = 1'b1;
							ctrl.regDst = controlPkg::dstRd;
							ctrl.writeData = controlPkg::wdShifter;
						end
					end
					controlPkg::clsJr:
					begin
						if (step == 3'd0)
						begin
							ctrl.aluSrcA = controlPkg::srcAJump;
							ctrl.aluSrcB = controlPkg::srcBZero;
							ctrl.aluOp = controlPkg::aluAdd;
							ctrl.aluOutWrite = 1'b1;
						end
						else if (step inside {3'd1, 3'd2})
						begin
							ctrl.pcWrite = 1'b1;
							ctrl.pcSource = controlPkg::pcAluOut;
						end
					end
					controlPkg::clsBreak:
					begin
						if (step == 3'd0)
						begin
							ctrl.aWrite = 1'b1;
							ctrl.bWrite = 1'b1;
							ctrl.aluSrcA = controlPkg::srcAPc;
							ctrl.aluSrcB = controlPkg::srcBFour;
							ctrl.aluOp = controlPkg::aluSub;
						end
						else if (step inside {3'd1, 3'd2, 3'd3})
						begin
							ctrl.pcWrite = 1'b1;
							ctrl.pcSource = controlPkg::pcAluResult;
						end
					end
					controlPkg::clsRte:
					begin
						ctrl.pcWrite = 1'b1;
						ctrl.pcSource = controlPkg::pcEpc;
					end
					controlPkg::clsBeq:
					begin
						// Target first, then compare, then conditional write
						if (step == 3'd1)
						begin
							ctrl.aluSrcA = controlPkg::srcAPc;
							ctrl.aluSrcB = controlPkg::srcBOffset;
							ctrl.aluOp = controlPkg::aluAdd;
							ctrl.aluOutWrite = 1'b1;
						end
						else if (step == 3'd3)
						begin
							ctrl.aWrite = 1'b1;
							ctrl.bWrite = 1'b1;
							ctrl.aluSrcA = controlPkg::srcARegA;
							ctrl.aluSrcB = controlPkg::srcBRegB;
							ctrl.aluOp = controlPkg::aluSub;
						end
						else if (step == 3'd4)
						begin
							ctrl.pcWriteCond = 1'b1;
							ctrl.branchEqual = 2'd1;
							ctrl.pcSource = controlPkg::pcAluOut;
						end
					end
					default:
						ctrl = '0;
				endcase
			end
			default:
				ctrl = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- sequencer/controlSequencer.sv
`default_nettype none

module controlSequencer (
	input wire clk,
	input wire arstN,
	input wire controlPkg::decodedT decoded,
	output controlPkg::phaseT phase,
	output controlPkg::stepT step,
	output controlPkg::decodedT instr
);

	// Last execute step of each class, one less than its length
	function automatic controlPkg::stepT lastStep(input controlPkg::instrClassT cls);
		case (cls)
			controlPkg::clsAluR:
				lastStep = 3'd3;
			controlPkg::clsAddi:
				lastStep = 3'd2;
			controlPkg::clsSlt:
				lastStep = 3'd3;
			controlPkg::clsShift:
				lastStep = 3'd4;
			controlPkg::clsJr:
				lastStep = 3'd3;
			controlPkg::clsBreak:
				lastStep = 3'd4;
			controlPkg::clsRte:
				lastStep = 3'd0;
			controlPkg::clsBeq:
				lastStep = 3'd6;
			default:
				lastStep = 3'd0;
		endcase
	endfunction

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			phase <= controlPkg::phReset;
			step <= '0;
		end
		else
		begin
			step <= '0;
			case (phase)
				controlPkg::phReset:
					phase <= controlPkg::phSpInit;
				controlPkg::phSpInit:
					phase <= controlPkg::phIdle;
				controlPkg::phIdle:
					phase <= controlPkg::phPcIncr;
				controlPkg::phPcIncr:
					phase <= controlPkg::phFetchWait;
				controlPkg::phFetchWait:
					phase <= controlPkg::phIrLoad;
				controlPkg::phIrLoad:
					phase <= controlPkg::phDecodeWait;
				controlPkg::phDecodeWait:
					phase <= controlPkg::phDispatch;
				controlPkg::phDispatch:
				begin
					// Unknown instructions go straight back to fetch
					if (decoded.cls == controlPkg::clsNone)
						phase <= controlPkg::phPcIncr;
					else
						phase <= controlPkg::phExecute;
				end
				controlPkg::phExecute:
				begin
					if (step == lastStep(instr.cls))
						phase <= controlPkg::phPcIncr;
					else
						step <= step + 3'd1;
				end
				default:
					phase <= controlPkg::phReset;
			endcase
		end
	end

	// Instruction held for the whole execute sequence
	always_ff @(posedge clk)
	begin
		if (phase == controlPkg::phDispatch)
			instr <= decoded;
	end

endmodule

`default_nettype wire

//--- source/instrDecode.sv
`default_nettype none

module instrDecode (
	input wire controlPkg::opcodeT opcode,
	input wire controlPkg::functT funct,
	output controlPkg::decodedT decoded
);

	always_comb
	begin
		decoded = '0;
		decoded.cls = controlPkg::clsNone;
		case (opcode)
			controlPkg::OpRType:
			begin
				case (funct)
					controlPkg::FnAdd:
					begin
						decoded.cls = controlPkg::clsAluR;
						decoded.aluOp = controlPkg::aluAdd;
					end
					controlPkg::FnSub:
					begin
						decoded.cls = controlPkg::clsAluR;
						decoded.aluOp = controlPkg::aluSub;
					end
					controlPkg::FnAnd:
					begin
						decoded.cls = controlPkg::clsAluR;
						decoded.aluOp = controlPkg::aluAnd;
					end
					controlPkg::FnSlt:
					begin
						decoded.cls = controlPkg::clsSlt;
						decoded.aluOp = controlPkg::aluSlt;
					end
					controlPkg::FnSrl:
					begin
						decoded.cls = controlPkg::clsShift;
						decoded.shiftOp = controlPkg::shRightLogic;
					end
					controlPkg::FnSra:
					begin
						decoded.cls = controlPkg::clsShift;
						decoded.shiftOp = controlPkg::shRightArith;
					end
					controlPkg::FnSll:
					begin
						decoded.cls = controlPkg::clsShift;
						decoded.shiftOp = controlPkg::shLeft;
					end
					// Shift amount taken from rs
					controlPkg::FnSllv:
					begin
						decoded.cls = controlPkg::clsShift;
						decoded.shiftOp = controlPkg::shLeft;
						decoded.shiftVariable = 1'b1;
					end
					controlPkg::FnSrav:
					begin
						decoded.cls = controlPkg::clsShift;
						decoded.shiftOp = controlPkg::shRightArith;
						decoded.shiftVariable = 1'b1;
					end
					controlPkg::FnJr:
						decoded.cls = controlPkg::clsJr;
					controlPkg::FnBreak:
						decoded.cls = controlPkg::clsBreak;
					controlPkg::FnRte:
						decoded.cls = controlPkg::clsRte;
					default:
						decoded.cls = controlPkg::clsNone;
				endcase
			end
			controlPkg::OpAddi:
			begin
				decoded.cls = controlPkg::clsAddi;
				decoded.aluOp = controlPkg::aluAdd;
			end
			controlPkg::OpBeq:
				decoded.cls = controlPkg::clsBeq;
			default:
				decoded.cls = controlPkg::clsNone;
		endcase
	end

endmodule

`default_nettype wire

//--- common/controlPkg.sv
`default_nettype none

package controlPkg;

	// Instruction fields
	typedef logic [5:0] opcodeT;
	typedef logic [5:0] functT;

	// Position inside an execute sequence
	typedef logic [2:0] stepT;

	typedef enum logic [2:0] {
		aluNone = 3'd0,
		aluAdd = 3'd1,
		aluSub = 3'd2,
		aluAnd = 3'd3,
		aluSlt = 3'd7
	} aluOpT;

	typedef enum logic [2:0] {
		srcAPc = 3'd0,
		srcAJump = 3'd3,
		srcARegA = 3'd4
	} aluSrcAT;

	typedef enum logic [2:0] {
		srcBRegB = 3'd0,
		srcBFour = 3'd1,
		srcBImm = 3'd2,
		srcBOffset = 3'd4,
		srcBZero = 3'd5
	} aluSrcBT;

	typedef enum logic [2:0] {
		pcAluResult = 3'd0,
		pcEpc = 3'd1,
		pcAluOut = 3'd2
	} pcSourceT;

	typedef enum logic [1:0] {
		dstRt = 2'd0,
		dstRd = 2'd1,
		dstStackPtr = 2'd3
	} regDstT;

	typedef enum logic [3:0] {
		wdAluOut = 4'd0,
		wdLessThan = 4'd3,
		wdShifter = 4'd4,
		wdSpInit = 4'd8
	} writeDataT;

	typedef enum logic [2:0] {
		shNone = 3'd0,
		shLeft = 3'd2,
		shRightLogic = 3'd3,
		shRightArith = 3'd4
	} shiftOpT;

	typedef enum logic [1:0] {
		ldNone = 2'd0,
		ldVariable = 2'd1,
		ldImmediate = 2'd2
	} shiftLoadT;

	// Full datapath control word with pcWrite in the top bit
	typedef struct packed {
		logic pcWrite;
		logic pcWriteCond;
		logic [1:0] branchEqual;
		pcSourceT pcSource;
		logic irWrite;
		logic regWrite;
		regDstT regDst;
		aluSrcAT aluSrcA;
		aluOpT aluOp;
		logic aluOutWrite;
		aluSrcBT aluSrcB;
		logic aWrite;
		logic bWrite;
		shiftOpT shiftOp;
		logic shamtFromField;
		shiftLoadT shiftLoad;
		writeDataT writeData;
	} ctrlWordT;

	typedef enum logic [3:0] {
		clsNone,
		clsAluR,
		clsAddi,
		clsSlt,
		clsShift,
		clsJr,
		clsBreak,
		clsRte,
		clsBeq
	} instrClassT;

	typedef struct packed {
		instrClassT cls;
		aluOpT aluOp;
		shiftOpT shiftOp;
		logic shiftVariable;
	} decodedT;

	typedef enum logic [3:0] {
		phReset,
		phSpInit,
		phIdle,
		phPcIncr,
		phFetchWait,
		phIrLoad,
		phDecodeWait,
		phDispatch,
		phExecute
	} phaseT;

	localparam opcodeT OpRType = 6'd0;
	localparam opcodeT OpAddi = 6'd8;
	localparam opcodeT OpBeq = 6'd4;

	localparam functT FnAdd = 6'd32;
	localparam functT FnSub = 6'd34;
	localparam functT FnSrl = 6'd2;
	localparam functT FnSra = 6'd3;
	localparam functT FnSll = 6'd0;
	localparam functT FnSlt = 6'd42;
	localparam functT FnAnd = 6'd36;
	localparam functT FnJr = 6'd8;
	localparam functT FnSllv = 6'd4;
	localparam functT FnSrav = 6'd7;
	localparam functT FnBreak = 6'd13;
	localparam functT FnRte = 6'd19;

endpackage

`default_nettype wire
